// File: hashcore.f
+incdir+bench
design/scrypt_pkg.sv
design/sha256_transform.sv
design/pbkdf2_sequencer.sv
design/xbuf_packer.sv
design/hashcore.sv
bench/clock_gen.sv
bench/hashcore_tb.sv

// File: Makefile
# Verilator build and run of the scrypt key expansion testbench

SRCS := $(filter %.sv,$(shell cat hashcore.f))

.PHONY: run clean

obj_dir/Vhashcore_tb: $(SRCS) bench/pbkdf2_vectors.svh hashcore.f
	verilator --binary --top-module hashcore_tb -Wno-fatal -f hashcore.f

run: obj_dir/Vhashcore_tb
	./obj_dir/Vhashcore_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/pbkdf2_vectors.svh
// PBKDF2 job vectors
`ifndef pbkdf2_vectors_svh
`define pbkdf2_vectors_svh

localparam int vec_count = 3;

// 80-byte headers, byte 0 leftmost, bytes 76..79 get the nonce
localparam logic [639:0] vec_header [vec_count] = '{
	{160'h01000000_ae178934_851bfa0e_83ccb6a3_fc4bfddf,
	 160'hf3641e5d_c7d2e7f1_2a4c8bd6_f2a3e901_00000000,
	 160'hc1a5f2de_6b8e3d27_94c0a7b1_5e3d9f20_8a61c4e7,
	 160'h3b0d52f9_a1b3c5e8_1d2c3b4a_5e6f7a8b_00000000},
	{160'h02000000_7f3e91c2_a45d0b8e_19c6f3a7_e28d4b05,
	 160'h6a1f9c3d_b7e24086_d9c5a13f_02b8e7d4_00000000,
	 160'h4e9a7c31_f80d26b5_c31e97a4_6d5b0f82_19e4a7c3,
	 160'hb5d8f026_53c4e89a_0f1e2d3c_4b5a6978_00000000},
	{160'h01000020_c9d3e5f7_1a2b3c4d_5e6f7081_92a3b4c5,
	 160'hd6e7f809_1b2c3d4e_5f607182_93a4b5c6_00000000,
	 160'h7e8f90a1_b2c3d4e5_f6071829_3a4b5c6d_7e8f9a0b,
	 160'h1c2d3e4f_50617283_94a5b6c7_d8e9fa0b_00000000}
};

localparam logic [3:0] vec_msb [vec_count] = '{4'h3, 4'hc, 4'h7};    // Core prefix

// Nonce at done, job index in the low 28 bits
localparam scrypt_pkg::nonce_t vec_nonce [vec_count] = '{
	32'h3000_0000, 32'hc000_0001, 32'h7000_0002
};

// Cycle after start of an extra start pulse, 0 for none
localparam int vec_restart [vec_count] = '{0, 400, 0};

`endif

// File: bench/hashcore_tb.sv
// Scrypt key expansion testbench
`timescale 1ns/10ps
`default_nettype none

module hashcore_tb;

	typedef logic [7:0] bytes_t [$];

	localparam int job_latency = 859;    // Start to done in cycles

	logic hash_clk, reset, start, done;
	logic [3:0] nonce_msb;
	scrypt_pkg::header_lo_t header_lo;
	scrypt_pkg::header_tail_t header_tail;
	scrypt_pkg::xbuf_t x_out;
	scrypt_pkg::nonce_t nonce_out;

	`include "pbkdf2_vectors.svh"

	localparam longint watchdog_ns = longint'(vec_count + 2) * job_latency * 4;

	logic [31:0] k_tab [64];      // Reference round constants
	logic [31:0] iv_tab [8];
	scrypt_pkg::xbuf_t exp_x [vec_count];

	clock_gen u_clk (.hash_clk(hash_clk), .reset(reset));

	hashcore u_hashcore (
		.hash_clk(hash_clk), .reset(reset), .start(start), .nonce_msb(nonce_msb),
		.header_lo(header_lo), .header_tail(header_tail),
		.done(done), .x_out(x_out), .nonce_out(nonce_out)
	);

	task automatic stop_run(string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_xbuf(string name, scrypt_pkg::xbuf_t exp, scrypt_pkg::xbuf_t act);
		if (act !== exp)
			stop_run($sformatf("mismatch %s x_out expected %h actual %h", name, exp, act));
	endtask

	task automatic check_nonce(string name, scrypt_pkg::nonce_t exp, scrypt_pkg::nonce_t act);
		if (act !== exp)
			stop_run($sformatf("mismatch %s nonce_out expected %h actual %h", name, exp, act));
	endtask

	// First 32 fraction bits of a real
	function automatic logic [31:0] frac_word(real v);
		real f;
		f = v - $floor(v);
		return 32'(longint'($floor(f * 4294967296.0)));
	endfunction

	// K from cube roots, IV from square roots of the first primes
	task automatic make_constants();
		int p, n;
		bit is_prime;
		n = 0;
		p = 2;
		while (n < 64) begin
			is_prime = 1'b1;
			for (int d = 2; d * d <= p; d++)
				if (p % d == 0)
					is_prime = 1'b0;
			if (is_prime) begin
				if (n < 8)
					iv_tab[n] = frac_word($sqrt(real'(p)));
				k_tab[n] = frac_word($pow(real'(p), 1.0 / 3.0));
				n++;
			end
			p++;
		end
	endtask

	function automatic logic [31:0] ror(logic [31:0] x, int n);
		return 32'({x, x} >> n);
	endfunction

	function automatic logic [31:0] small_sigma0(logic [31:0] x);
		return ror(x, 7) ^ ror(x, 18) ^ (x >> 3);
	endfunction

	function automatic logic [31:0] small_sigma1(logic [31:0] x);
		return ror(x, 17) ^ ror(x, 19) ^ (x >> 10);
	endfunction

	function automatic logic [31:0] big_sigma0(logic [31:0] x);
		return ror(x, 2) ^ ror(x, 13) ^ ror(x, 22);
	endfunction

	function automatic logic [31:0] big_sigma1(logic [31:0] x);
		return ror(x, 6) ^ ror(x, 11) ^ ror(x, 25);
	endfunction

	// Byte-oriented SHA-256, digest byte 0 in the top bits
	function automatic logic [255:0] sha256(bytes_t msg);
		bytes_t m;
		logic [31:0] hs [8];
		logic [31:0] v [8];
		logic [31:0] w [64];
		logic [31:0] t1, t2;
		logic [63:0] bit_len;
		m = msg;
		bit_len = 64'(msg.size()) * 64'd8;
		m.push_back(8'h80);
		while (m.size() % 64 != 56)
			m.push_back(8'h00);
		for (int i = 7; i >= 0; i--)
			m.push_back(bit_len[8*i +: 8]);    // Length big-endian
		hs = iv_tab;
		for (int base = 0; base < m.size(); base += 64) begin
			for (int t = 0; t < 16; t++)
				w[t] = {m[base+4*t], m[base+4*t+1], m[base+4*t+2], m[base+4*t+3]};
			for (int t = 16; t < 64; t++)
				w[t] = small_sigma1(w[t-2]) + w[t-7] + small_sigma0(w[t-15]) + w[t-16];
			v = hs;
			for (int t = 0; t < 64; t++) begin
				t1 = v[7] + big_sigma1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6])) + k_tab[t] + w[t];
				t2 = big_sigma0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
				for (int j = 7; j > 0; j--)
					v[j] = v[j-1];
				v[4] = v[4] + t1;                  // Old d plus t1
				v[0] = t1 + t2;
			end
			for (int j = 0; j < 8; j++)
				hs[j] = hs[j] + v[j];
		end
		return {hs[0], hs[1], hs[2], hs[3], hs[4], hs[5], hs[6], hs[7]};
	endfunction

	function automatic bytes_t digest_bytes(logic [255:0] d);
		bytes_t q;
		for (int i = 0; i < 32; i++)
			q.push_back(d[255-8*i -: 8]);
		return q;
	endfunction

	function automatic logic [255:0] hmac_sha256(bytes_t key, bytes_t msg);
		bytes_t k, inner, outer;
		if (key.size() > 64)
			k = digest_bytes(sha256(key));     // Long keys are hashed first
		else
			k = key;
		while (k.size() < 64)
			k.push_back(8'h00);
		for (int i = 0; i < 64; i++) begin
			inner.push_back(k[i] ^ 8'h36);
			outer.push_back(k[i] ^ 8'h5c);
		end
		foreach (msg[i])
			inner.push_back(msg[i]);
		k = digest_bytes(sha256(inner));
		foreach (k[i])
			outer.push_back(k[i]);
		return sha256(outer);
	endfunction

	// PBKDF2 with the header as password and salt, one iteration, 128 bytes
	function automatic scrypt_pkg::xbuf_t expected_x(logic [639:0] hdr, scrypt_pkg::nonce_t nonce);
		bytes_t pw, salt;
		scrypt_pkg::xbuf_t x;
		logic [255:0] t;
		for (int i = 0; i < 76; i++)
			pw.push_back(hdr[639-8*i -: 8]);
		for (int i = 0; i < 4; i++)
			pw.push_back(nonce[8*i +: 8]);     // Little-endian nonce in bytes 76..79
		for (int blk = 1; blk <= 4; blk++) begin
			salt = pw;
			salt.push_back(8'h00);
			salt.push_back(8'h00);
			salt.push_back(8'h00);
			salt.push_back(8'(blk));
			t = hmac_sha256(pw, salt);
			for (int j = 0; j < 32; j++)
				x[8*(32*(blk-1)+j) +: 8] = t[255-8*j -: 8];    // Byte k of the key at bits 8k
		end
		return x;
	endfunction

	// SHA word i of the DUT bus carries bytes 4i..4i+3
	function automatic scrypt_pkg::header_lo_t to_header_lo(logic [639:0] hdr);
		scrypt_pkg::header_lo_t h;
		for (int w = 0; w < 16; w++)
			h[32*w +: 32] = hdr[639-32*w -: 32];
		return h;
	endfunction

	function automatic scrypt_pkg::header_tail_t to_header_tail(logic [639:0] hdr);
		scrypt_pkg::header_tail_t h;
		for (int w = 0; w < 3; w++)
			h[32*w +: 32] = hdr[639-32*(16+w) -: 32];
		return h;
	endfunction

	task automatic expect_idle(int cycles);
		repeat (cycles) begin
			@(negedge hash_clk);
			if (done !== 1'b0)
				stop_run("done pulsed while no job was running");
		end
	endtask

	task automatic run_job(int i);
		string name;
		name = $sformatf("job %0d", i);
		@(posedge hash_clk);
		start <= 1'b1;
		nonce_msb <= vec_msb[i];
		header_lo <= to_header_lo(vec_header[i]);
		header_tail <= to_header_tail(vec_header[i]);
		@(posedge hash_clk);                   // DUT takes start here
		start <= 1'b0;
		for (int cyc = 1; cyc <= job_latency; cyc++) begin
			@(posedge hash_clk);
			start <= (cyc == vec_restart[i]);  // Extra start while busy
			@(negedge hash_clk);
			if (done === 1'b1 && cyc < job_latency)
				stop_run($sformatf("%s: done came %0d cycles after start, too early", name, cyc));
		end
		if (done !== 1'b1)
			stop_run($sformatf("%s: done missing %0d cycles after start", name, job_latency));
		check_xbuf(name, exp_x[i], x_out);
		check_nonce(name, vec_nonce[i], nonce_out);
	endtask

	initial begin
		#(watchdog_ns);
		stop_run("watchdog expired before all jobs finished");
	end

	initial begin
		int gap;
		start = 1'b0;
		nonce_msb = 4'h0;
		header_lo = '0;
		header_tail = '0;
		void'($urandom(32'h3ec2));
		make_constants();
		for (int i = 0; i < vec_count; i++)
			exp_x[i] = expected_x(vec_header[i], vec_nonce[i]);
		@(negedge reset);
		expect_idle(20);                       // No done without a start
		for (int i = 0; i < vec_count; i++) begin
			run_job(i);
			gap = $urandom_range(8, 1);
			expect_idle(gap);                  // Also proves done is one cycle wide
		end
		expect_idle(20);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
	output logic hash_clk,
	output logic reset
);
	initial begin
		hash_clk = 1'b0;
		forever #2 hash_clk = ~hash_clk;    // 4 ns period
	end

	// Reset held for the first 16 rising edges
	initial begin
		reset = 1'b1;
		repeat (16) @(posedge hash_clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: design/hashcore.sv
// Scrypt key expansion top
`timescale 1ns/10ps
`default_nettype none

module hashcore (
	input  logic                     hash_clk,
	input  logic                     reset,
	input  logic                     start,          // Ignored while a job runs
	input  logic [3:0]               nonce_msb,
	input  scrypt_pkg::header_lo_t   header_lo,
	input  scrypt_pkg::header_tail_t header_tail,
	output logic                     done,
	output scrypt_pkg::xbuf_t        x_out,
	output scrypt_pkg::nonce_t       nonce_out
);
	logic load, digest_valid, capture, finish;
	scrypt_pkg::digest_t state_in, digest;
	scrypt_pkg::block_t block_in;

	pbkdf2_sequencer u_sequencer (
		.hash_clk(hash_clk), .reset(reset), .start(start), .nonce_msb(nonce_msb),
		.header_lo(header_lo), .header_tail(header_tail),
		.digest(digest), .digest_valid(digest_valid),
		.load(load), .state_in(state_in), .block_in(block_in),
		.capture(capture), .finish(finish), .nonce_out(nonce_out)
	);

	sha256_transform u_sha (
		.hash_clk(hash_clk), .reset(reset), .load(load),
		.state_in(state_in), .block_in(block_in),
		.digest(digest), .digest_valid(digest_valid)
	);

	xbuf_packer u_packer (
		.hash_clk(hash_clk), .reset(reset), .capture(capture), .finish(finish),
		.digest(digest), .done(done), .x_out(x_out)
	);

endmodule

`default_nettype wire

// File: design/xbuf_packer.sv
// X buffer packer
`timescale 1ns/10ps
`default_nettype none

module xbuf_packer (
	input  logic                hash_clk,
	input  logic                reset,
	input  logic                capture,
	input  logic                finish,
	input  scrypt_pkg::digest_t digest,
	output logic                done,
	output scrypt_pkg::xbuf_t   x_out
);
	scrypt_pkg::xbuf_t xbuf, x_le;

	// Byte-reverse each word to the little-endian layout salsa expects
	always_comb begin
		for (int i = 0; i < scrypt_pkg::xfer_words; i++)
			x_le[32*i +: 32] = {xbuf[32*i +: 8], xbuf[32*i+8 +: 8],
				xbuf[32*i+16 +: 8], xbuf[32*i+24 +: 8]};
	end

	always_ff @(posedge hash_clk) begin
		if (capture)
			xbuf <= {digest, xbuf[1023:256]};    // Block 1 ends up in the low quarter
	end

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			done <= 1'b0;
			x_out <= '0;
		end else begin
			done <= finish;
			if (finish)
				x_out <= x_le;                   // Held until the next job
		end
	end

endmodule

`default_nettype wire

// File: design/pbkdf2_sequencer.sv
// PBKDF2 transform sequencer
`timescale 1ns/10ps
`default_nettype none

module pbkdf2_sequencer (
	input  logic                     hash_clk,
	input  logic                     reset,
	input  logic                     start,
	input  logic [3:0]               nonce_msb,      // Core prefix
	input  scrypt_pkg::header_lo_t   header_lo,      // SHA word i holds bytes 4i..4i+3
	input  scrypt_pkg::header_tail_t header_tail,    // Header words 16..18
	input  scrypt_pkg::digest_t      digest,
	input  logic                     digest_valid,
	output logic                     load,
	output scrypt_pkg::digest_t      state_in,
	output scrypt_pkg::block_t       block_in,
	output logic                     capture,
	output logic                     finish,
	output scrypt_pkg::nonce_t       nonce_out
);
	localparam logic [3:0] ph_idle   = 4'd0;
	localparam logic [3:0] ph_key1   = 4'd1;    // Key hash, header bytes 0..63
	localparam logic [3:0] ph_key2   = 4'd2;    // Key hash, tail with nonce
	localparam logic [3:0] ph_ipad1  = 4'd3;
	localparam logic [3:0] ph_ipad2  = 4'd4;    // Inner hash continues over header bytes 0..63
	localparam logic [3:0] ph_opad   = 4'd5;
	localparam logic [3:0] ph_iter1  = 4'd6;    // Inner hash of salt tail and block count
	localparam logic [3:0] ph_iter2  = 4'd7;    // Outer hash of the inner digest
	localparam logic [3:0] ph_finish = 4'd8;

	logic [3:0] phase;
	logic [2:0] blk_cnt;                                   // PBKDF2 block index 1..4
	logic [scrypt_pkg::nonce_cnt_w-1:0] nonce_cnt;
	scrypt_pkg::digest_t khash, ihash, ohash;
	scrypt_pkg::nonce_t nonce, nonce_le;
	scrypt_pkg::block_t tail_block, iter_block;

	assign nonce = {nonce_msb, nonce_cnt};
	// Nonce sits little-endian in bytes 76..79
	assign nonce_le = {nonce[7:0], nonce[15:8], nonce[23:16], nonce[31:24]};
	assign tail_block = {scrypt_pkg::header_pad, nonce_le, header_tail};
	assign iter_block = {scrypt_pkg::iter_pad, 29'd0, blk_cnt, nonce_le, header_tail};
	assign capture = digest_valid && (phase == ph_iter2);     // One X slice per block
	assign finish = (phase == ph_finish);

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			phase <= ph_idle;
			load <= 1'b0;
			blk_cnt <= '0;
			nonce_cnt <= '0;
		end else begin
			load <= 1'b0;
			case (phase)
				ph_idle: begin
					if (start) begin
						phase <= ph_key1;
						load <= 1'b1;
						blk_cnt <= 3'd1;
					end
				end
				ph_finish: begin
					phase <= ph_idle;
					nonce_cnt <= nonce_cnt + 1'b1;     // Next job's nonce
				end
				default: begin
					if (digest_valid) begin
						load <= 1'b1;
						case (phase)
							ph_key1:  phase <= ph_key2;
							ph_key2:  phase <= ph_ipad1;
							ph_ipad1: phase <= ph_ipad2;
							ph_ipad2: phase <= ph_opad;
							ph_opad:  phase <= ph_iter1;
							ph_iter1: begin
								phase <= ph_iter2;
								blk_cnt <= blk_cnt + 3'd1;   // Points at the next block from here
							end
							default: begin
								if (blk_cnt == 3'd5) begin
									phase <= ph_finish;
									load <= 1'b0;
								end else
									phase <= ph_iter1;
							end
						endcase
					end
				end
			endcase
		end
	end

	// Chaining value and block for the next load
	always_ff @(posedge hash_clk) begin
		if (phase == ph_idle && start) begin
			state_in <= scrypt_pkg::sha256_iv;
			block_in <= header_lo;
		end
		if (digest_valid) begin
			case (phase)
				ph_key1: begin
					state_in <= digest;
					block_in <= tail_block;
				end
				ph_key2: begin
					khash <= digest;
					state_in <= scrypt_pkg::sha256_iv;
					block_in <= {256'd0, digest} ^ scrypt_pkg::ipad_block;
				end
				ph_ipad1: begin
					state_in <= digest;
					block_in <= header_lo;                // Salt is the header itself
				end
				ph_ipad2: begin
					ihash <= digest;
					state_in <= scrypt_pkg::sha256_iv;
					block_in <= {256'd0, khash} ^ scrypt_pkg::opad_block;
				end
				ph_opad: begin
					ohash <= digest;
					state_in <= ihash;
					block_in <= iter_block;
				end
				ph_iter1: begin
					state_in <= ohash;
					block_in <= {scrypt_pkg::digest_pad, digest};
				end
				ph_iter2: begin
					state_in <= ihash;
					block_in <= iter_block;               // Unused after block 4
				end
				default: ;
			endcase
		end
		if (finish)
			nonce_out <= nonce;    // Nonce of the job just completed
	end

endmodule

`default_nettype wire

// File: design/sha256_transform.sv
// SHA-256 compression core
`timescale 1ns/10ps
`default_nettype none

module sha256_transform (
	input  logic                hash_clk,
	input  logic                reset,
	input  logic                load,          // Starts a transform
	input  scrypt_pkg::digest_t state_in,      // Chaining value held through the transform
	input  scrypt_pkg::block_t  block_in,      // Only sampled with load
	output scrypt_pkg::digest_t digest,
	output logic                digest_valid
);
	// Cycle count on which the chaining add happens
	localparam logic [6:0] add_cnt = 7'(scrypt_pkg::transform_cycles - 32'd2);

	logic [6:0] cnt;                                     // Cycles since load or 0 when idle
	scrypt_pkg::digest_t work, cur_work, next_work;      // a in word 0 up to h in word 7
	scrypt_pkg::block_t sched, cur_sched;                // W[t] in word 0
	scrypt_pkg::word_t a, b, c, d, e, f, g, h;
	scrypt_pkg::word_t w0, w1, w9, w14, w_new, k_t, t1, t2;

	function automatic scrypt_pkg::word_t rotr(scrypt_pkg::word_t x, int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// One round per cycle with round 0 taken straight off the ports
	always_comb begin
		cur_work = load ? state_in : work;
		cur_sched = load ? block_in : sched;
		{h, g, f, e, d, c, b, a} = cur_work;
		w0 = cur_sched[31:0];
		w1 = cur_sched[63:32];
		w9 = cur_sched[319:288];
		w14 = cur_sched[479:448];
		k_t = scrypt_pkg::sha256_k[cnt[5:0]];    // cnt is still 0 on the load cycle
		t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g)) + k_t + w0;
		t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
		next_work = {g, f, e, d + t1, c, b, a, t1 + t2};
		// W[t+16] for the rolling window
		w_new = (rotr(w14, 17) ^ rotr(w14, 19) ^ (w14 >> 10)) + w9
			+ (rotr(w1, 7) ^ rotr(w1, 18) ^ (w1 >> 3)) + w0;
	end

	always_ff @(posedge hash_clk) begin
		if (reset) begin
			cnt <= '0;
			digest_valid <= 1'b0;
		end else begin
			digest_valid <= 1'b0;
			if (load)
				cnt <= 7'd1;                 // Round 0 done on the load edge
			else if (cnt == add_cnt) begin
				cnt <= '0;
				digest_valid <= 1'b1;
			end else if (cnt != 7'd0)
				cnt <= cnt + 7'd1;
		end
	end

	always_ff @(posedge hash_clk) begin
		if (load || (cnt != 7'd0 && cnt != add_cnt)) begin
			work <= next_work;                      // Rounds 0..63
			sched <= {w_new, cur_sched[511:32]};    // Shift W down one word
		end
		if (cnt == add_cnt) begin
			for (int i = 0; i < 8; i++)
				digest[32*i +: 32] <= state_in[32*i +: 32] + work[32*i +: 32];
		end
	end

endmodule

`default_nettype wire

// File: design/scrypt_pkg.sv
// Scrypt hash core definitions
`default_nettype none

package scrypt_pkg;

	// Bus widths
	typedef logic [31:0]   word_t;         // One SHA-256 word
	typedef logic [255:0]  digest_t;       // Hash state, word 0 (a) in the low bits
	typedef logic [511:0]  block_t;        // Message block, W[0] in the low bits
	typedef logic [1023:0] xbuf_t;         // Scrypt X buffer
	typedef logic [31:0]   nonce_t;
	typedef logic [511:0]  header_lo_t;    // Header bytes 0..63
	typedef logic [95:0]   header_tail_t;  // Header bytes 64..75

	// Cycles from one load to the next
	localparam word_t transform_cycles = 32'd66;
	localparam word_t xfer_words = 32'd32;     // 32-bit words in X
	localparam word_t nonce_cnt_w = 32'd28;    // Low nonce bits, core prefix sits above

	// FIPS 180-4 initial hash value, h0 in the low word
	localparam digest_t sha256_iv = {
		32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
		32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
	};

	// Round constants, K[0] first
	localparam word_t sha256_k [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// HMAC pads, key is 32 bytes so the upper half is pad only
	localparam block_t ipad_block = {16{32'h36363636}};
	localparam block_t opad_block = {16{32'h5c5c5c5c}};

	// Words 4..15 after the header tail, message is 80 bytes
	localparam logic [383:0] header_pad = {
		32'h00000280,       // 640 bits
		320'd0,
		32'h80000000        // Stop bit
	};

	// Words 5..15 after salt tail plus block count, 64 + 80 + 4 bytes
	localparam logic [351:0] iter_pad = {
		32'h000004a0,
		288'd0,
		32'h80000000
	};

	// Words 8..15 after a 32-byte inner digest, 64 + 32 bytes
	localparam logic [255:0] digest_pad = {
		32'h00000300,
		192'd0,
		32'h80000000
	};

endpackage

`default_nettype wire
